/* rtl/gfx_pkg.sv */
package gfx_pkg;

  // active area
  localparam int fb_width = 8;
  localparam int fb_height = 4;

  // full raster including blanking
  localparam int h_total = 12;
  localparam int v_total = 6;
  localparam int hsync_start = 9;
  localparam int hsync_len = 2;
  localparam int vsync_line = 5;

  localparam int fb_x_bits = 3;
  localparam int fb_y_bits = 2;
  localparam int h_bits = $clog2(h_total);
  localparam int v_bits = $clog2(v_total);

  // words per bank
  localparam int fb_depth = 32;

  typedef struct packed {
    logic [3:0] red;
    logic [3:0] grn;
    logic [3:0] blu;
  } pixel_t;

  typedef logic [3:0] frame_num_t;

  typedef enum logic [1:0] {idle, addr_data, wait_resp, frame_hold} writer_state_t;

  typedef enum logic [1:0] {wait_enable, slot, read_wait, present} stream_state_t;

  // test pattern: frame number in red, x in green, y in blue
  function automatic pixel_t pattern_pixel(frame_num_t n, logic [fb_x_bits-1:0] x,
                                           logic [fb_y_bits-1:0] y);
    pixel_t p;
    p.red = n;
    p.grn = {1'b0, x};
    p.blu = {2'b00, y};
    return p;
  endfunction

endpackage

/* rtl/axi_lite_pkg.sv */
package axi_lite_pkg;

  // word addressed, one pixel per word
  localparam int axi_addr_bits = 5;
  localparam int axi_data_bits = 16;
  localparam int axi_strb_bits = axi_data_bits / 8;

  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_slverr = 2'b10
  } axi_resp_t;

endpackage

/* rtl/gfx_test_pattern.sv */
`timescale 1ns/10ps

module gfx_test_pattern (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         restart,
  input  logic                         take,
  output logic [gfx_pkg::fb_x_bits-1:0] x,
  output logic [gfx_pkg::fb_y_bits-1:0] y,
  output gfx_pkg::pixel_t              pixel,
  output logic                         valid,
  output logic                         last
);
  import gfx_pkg::*;

  frame_num_t frame_num;
  logic       x_end;

  assign x_end = (x == fb_x_bits'(fb_width - 1));
  assign last = x_end && (y == fb_y_bits'(fb_height - 1));
  assign pixel = pattern_pixel(frame_num, x, y);

  always_ff @(posedge clk) begin
    if (reset) begin
      x <= '0;
      y <= '0;
      frame_num <= '0;
      valid <= 1'b1;
    end else if (restart) begin
      // new frame starts at the origin with the next number
      x <= '0;
      y <= '0;
      frame_num <= frame_num + 1'b1;
      valid <= 1'b1;
    end else if (valid && take) begin
      if (last) begin
        // idle until the controller swaps banks
        valid <= 1'b0;
      end else if (x_end) begin
        x <= '0;
        y <= y + 1'b1;
      end else begin
        x <= x + 1'b1;
      end
    end
  end

endmodule

/* rtl/fb_writer.sv */
`timescale 1ns/10ps

module fb_writer (
  input  logic                                   clk,
  input  logic                                   reset,
  input  logic                                   pix_valid,
  input  logic                                   pix_last,
  input  logic [gfx_pkg::fb_x_bits-1:0]          x,
  input  logic [gfx_pkg::fb_y_bits-1:0]          y,
  input  gfx_pkg::pixel_t                        pixel,
  output logic                                   pix_take,
  input  logic                                   swap,
  output logic [axi_lite_pkg::axi_addr_bits-1:0] awaddr,
  output logic                                   awvalid,
  input  logic                                   awready,
  output logic [axi_lite_pkg::axi_data_bits-1:0] wdata,
  output logic [axi_lite_pkg::axi_strb_bits-1:0] wstrb,
  output logic                                   wvalid,
  input  logic                                   wready,
  input  axi_lite_pkg::axi_resp_t                bresp,
  input  logic                                   bvalid,
  output logic                                   bready,
  output logic                                   frame_written
);
  import gfx_pkg::*;
  import axi_lite_pkg::*;

  writer_state_t state;
  logic          last_pix;

  assign pix_take = (state == idle) && pix_valid;

  // address and data go out together
  assign awvalid = (state == addr_data);
  assign wvalid = (state == addr_data);
  assign bready = (state == wait_resp);
  assign wstrb = '1;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= idle;
      frame_written <= 1'b0;
    end else begin
      frame_written <= 1'b0;
      case (state)
        idle: begin
          if (pix_valid) begin
            state <= addr_data;
          end
        end
        addr_data: begin
          if (awready && wready) begin
            state <= wait_resp;
          end
        end
        wait_resp: begin
          if (bvalid) begin
            if (bresp != resp_okay) begin
              // reissue the same word
              state <= addr_data;
            end else if (last_pix) begin
              state <= frame_hold;
              frame_written <= 1'b1;
            end else begin
              state <= idle;
            end
          end
        end
        frame_hold: begin
          if (swap) begin
            state <= idle;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // word address is y * fb_width + x
  always_ff @(posedge clk) begin
    if (pix_take) begin
      awaddr <= axi_addr_bits'(int'(y) * fb_width + int'(x));
      wdata <= axi_data_bits'(pixel);
      last_pix <= pix_last;
    end
  end

endmodule

/* rtl/dbuf_controller.sv */
`timescale 1ns/10ps

module dbuf_controller (
  input  logic                                   clk,
  input  logic                                   reset,
  input  logic                                   frame_written,
  input  logic                                   frame_start,
  output logic                                   swap,
  output logic                                   display_enable,
  input  logic [axi_lite_pkg::axi_addr_bits-1:0] awaddr,
  input  logic                                   awvalid,
  output logic                                   awready,
  input  logic [axi_lite_pkg::axi_data_bits-1:0] wdata,
  input  logic [axi_lite_pkg::axi_strb_bits-1:0] wstrb,
  input  logic                                   wvalid,
  output logic                                   wready,
  output axi_lite_pkg::axi_resp_t                bresp,
  output logic                                   bvalid,
  input  logic                                   bready,
  input  logic [axi_lite_pkg::axi_addr_bits-1:0] araddr,
  input  logic                                   arvalid,
  output logic                                   arready,
  output logic [axi_lite_pkg::axi_data_bits-1:0] rdata,
  output axi_lite_pkg::axi_resp_t                rresp,
  output logic                                   rvalid,
  input  logic                                   rready
);
  import gfx_pkg::*;
  import axi_lite_pkg::*;

  pixel_t bank0 [fb_depth];
  pixel_t bank1 [fb_depth];

  // writes go to write_sel, reads to the other bank
  logic   write_sel;
  logic   first_swap;
  logic   first_done;
  logic   pending;
  logic   wr_fire;
  logic   wr_ok;
  logic   rd_fire;
  logic   rd_ok;
  pixel_t wr_old;
  pixel_t wr_new;
  pixel_t rd_pix;

  // aw and w are taken together once the previous b is gone
  assign wr_fire = awvalid && wvalid && !bvalid;
  assign awready = wr_fire;
  assign wready = wr_fire;
  assign wr_ok = int'(awaddr) < fb_depth;

  assign arready = !rvalid;
  assign rd_fire = arvalid && arready;
  assign rd_ok = int'(araddr) < fb_depth;
  assign rd_pix = write_sel ? bank0[araddr] : bank1[araddr];

  // byte lane merge, lane 1 holds only the red nibble
  always_comb begin
    wr_old = write_sel ? bank1[awaddr] : bank0[awaddr];
    wr_new = wr_old;
    if (wstrb[0]) begin
      wr_new[7:0] = wdata[7:0];
    end
    if (wstrb[1]) begin
      wr_new[11:8] = wdata[11:8];
    end
  end

  always_ff @(posedge clk) begin
    if (wr_fire && wr_ok) begin
      if (write_sel) begin
        bank1[awaddr] <= wr_new;
      end else begin
        bank0[awaddr] <= wr_new;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      bvalid <= 1'b0;
      rvalid <= 1'b0;
    end else begin
      if (wr_fire) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
      if (rd_fire) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      bresp <= wr_ok ? resp_okay : resp_slverr;
    end
    if (rd_fire) begin
      rdata <= rd_ok ? axi_data_bits'(rd_pix) : '0;
      rresp <= rd_ok ? resp_okay : resp_slverr;
    end
  end

  // first frame swaps right away, later ones wait for a display frame start
  assign swap = first_swap || (frame_start && pending);

  always_ff @(posedge clk) begin
    if (reset) begin
      write_sel <= 1'b0;
      first_swap <= 1'b0;
      first_done <= 1'b0;
      pending <= 1'b0;
      display_enable <= 1'b0;
    end else begin
      first_swap <= frame_written && !first_done;
      if (first_swap) begin
        first_done <= 1'b1;
      end
      if (swap) begin
        write_sel <= !write_sel;
        display_enable <= 1'b1;
        pending <= 1'b0;
      end else if (frame_written && first_done) begin
        pending <= 1'b1;
      end
    end
  end

endmodule

/* rtl/fb_pixel_stream.sv */
`timescale 1ns/10ps

module fb_pixel_stream (
  input  logic                                   clk,
  input  logic                                   reset,
  input  logic                                   display_enable,
  output logic                                   frame_start,
  output logic [axi_lite_pkg::axi_addr_bits-1:0] araddr,
  output logic                                   arvalid,
  input  logic                                   arready,
  input  logic [axi_lite_pkg::axi_data_bits-1:0] rdata,
  input  axi_lite_pkg::axi_resp_t                rresp,
  input  logic                                   rvalid,
  output logic                                   rready,
  output logic                                   pixel_valid,
  input  logic                                   pixel_ready,
  output gfx_pkg::pixel_t                        pixel,
  output logic                                   hsync,
  output logic                                   vsync,
  output logic                                   active
);
  import gfx_pkg::*;
  import axi_lite_pkg::*;

  stream_state_t     state;
  logic [h_bits-1:0] h;
  logic [v_bits-1:0] v;
  logic [h_bits-1:0] h_next;
  logic [v_bits-1:0] v_next;
  logic [h_bits-1:0] target_h;
  logic [v_bits-1:0] target_v;
  logic              enter_slot;
  logic              target_active;

  function automatic logic slot_active(logic [h_bits-1:0] sh, logic [v_bits-1:0] sv);
    return (int'(sh) < fb_width) && (int'(sv) < fb_height);
  endfunction

  // raster position after the current slot
  always_comb begin
    if (int'(h) == h_total - 1) begin
      h_next = '0;
      if (int'(v) == v_total - 1) begin
        v_next = '0;
      end else begin
        v_next = v + 1'b1;
      end
    end else begin
      h_next = h + 1'b1;
      v_next = v;
    end
  end

  // a slot is entered on enable or when the current beat is taken
  assign enter_slot = ((state == wait_enable) && display_enable) ||
                      ((state == present) && pixel_ready);
  assign target_h = (state == wait_enable) ? '0 : h_next;
  assign target_v = (state == wait_enable) ? '0 : v_next;
  assign target_active = slot_active(target_h, target_v);

  // hold the first read back one cycle so a swap on frame_start lands first
  assign arvalid = (state == slot) && !frame_start;
  assign araddr = axi_addr_bits'(int'(v[fb_y_bits-1:0]) * fb_width + int'(h[fb_x_bits-1:0]));
  assign rready = (state == read_wait);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= wait_enable;
      h <= '0;
      v <= '0;
      frame_start <= 1'b0;
      pixel_valid <= 1'b0;
    end else begin
      frame_start <= 1'b0;
      if (enter_slot) begin
        h <= target_h;
        v <= target_v;
        frame_start <= (target_h == '0) && (target_v == '0);
        if (target_active) begin
          pixel_valid <= 1'b0;
          state <= slot;
        end else begin
          // blanking beat is ready at once
          pixel_valid <= 1'b1;
          state <= present;
        end
      end else begin
        case (state)
          slot: begin
            if (arvalid && arready) begin
              state <= read_wait;
            end
          end
          read_wait: begin
            if (rvalid) begin
              pixel_valid <= 1'b1;
              state <= present;
            end
          end
          default: begin
          end
        endcase
      end
    end
  end

  // beat payload
  always_ff @(posedge clk) begin
    if (enter_slot) begin
      hsync <= (int'(target_h) >= hsync_start) && (int'(target_h) < hsync_start + hsync_len);
      vsync <= (int'(target_v) == vsync_line);
      active <= target_active;
      pixel <= '0;
    end else if ((state == read_wait) && rvalid) begin
      pixel <= (rresp == resp_okay) ? pixel_t'(rdata[$bits(pixel_t)-1:0]) : '0;
    end
  end

endmodule

/* rtl/gfx_demo_dbuf.sv */
`timescale 1ns/10ps

module gfx_demo_dbuf (
  input  logic            clk,
  input  logic            reset,
  input  logic            pixel_ready,
  output logic            pixel_valid,
  output gfx_pkg::pixel_t pixel,
  output logic            hsync,
  output logic            vsync,
  output logic            active
);
  import gfx_pkg::*;
  import axi_lite_pkg::*;

  // pattern to writer
  logic [fb_x_bits-1:0] gfx_x;
  logic [fb_y_bits-1:0] gfx_y;
  pixel_t               gfx_pixel;
  logic                 gfx_valid;
  logic                 gfx_last;
  logic                 gfx_take;

  // writer to controller
  logic [axi_addr_bits-1:0] awaddr;
  logic                     awvalid;
  logic                     awready;
  logic [axi_data_bits-1:0] wdata;
  logic [axi_strb_bits-1:0] wstrb;
  logic                     wvalid;
  logic                     wready;
  axi_resp_t                bresp;
  logic                     bvalid;
  logic                     bready;

  // stream to controller
  logic [axi_addr_bits-1:0] araddr;
  logic                     arvalid;
  logic                     arready;
  logic [axi_data_bits-1:0] rdata;
  axi_resp_t                rresp;
  logic                     rvalid;
  logic                     rready;

  // swap control
  logic frame_written;
  logic frame_start;
  logic swap;
  logic display_enable;

  gfx_test_pattern pattern_inst (
    .clk    (clk),
    .reset  (reset),
    .restart(swap),
    .take   (gfx_take),
    .x      (gfx_x),
    .y      (gfx_y),
    .pixel  (gfx_pixel),
    .valid  (gfx_valid),
    .last   (gfx_last)
  );

  fb_writer writer_inst (
    .clk          (clk),
    .reset        (reset),
    .pix_valid    (gfx_valid),
    .pix_last     (gfx_last),
    .x            (gfx_x),
    .y            (gfx_y),
    .pixel        (gfx_pixel),
    .pix_take     (gfx_take),
    .swap         (swap),
    .awaddr       (awaddr),
    .awvalid      (awvalid),
    .awready      (awready),
    .wdata        (wdata),
    .wstrb        (wstrb),
    .wvalid       (wvalid),
    .wready       (wready),
    .bresp        (bresp),
    .bvalid       (bvalid),
    .bready       (bready),
    .frame_written(frame_written)
  );

  dbuf_controller dbuf_inst (
    .clk           (clk),
    .reset         (reset),
    .frame_written (frame_written),
    .frame_start   (frame_start),
    .swap          (swap),
    .display_enable(display_enable),
    .awaddr        (awaddr),
    .awvalid       (awvalid),
    .awready       (awready),
    .wdata         (wdata),
    .wstrb         (wstrb),
    .wvalid        (wvalid),
    .wready        (wready),
    .bresp         (bresp),
    .bvalid        (bvalid),
    .bready        (bready),
    .araddr        (araddr),
    .arvalid       (arvalid),
    .arready       (arready),
    .rdata         (rdata),
    .rresp         (rresp),
    .rvalid        (rvalid),
    .rready        (rready)
  );

  fb_pixel_stream stream_inst (
    .clk           (clk),
    .reset         (reset),
    .display_enable(display_enable),
    .frame_start   (frame_start),
    .araddr        (araddr),
    .arvalid       (arvalid),
    .arready       (arready),
    .rdata         (rdata),
    .rresp         (rresp),
    .rvalid        (rvalid),
    .rready        (rready),
    .pixel_valid   (pixel_valid),
    .pixel_ready   (pixel_ready),
    .pixel         (pixel),
    .hsync         (hsync),
    .vsync         (vsync),
    .active        (active)
  );

endmodule

/* tb/gfx_demo_dbuf_sva.sv */
`timescale 1ns/10ps

module gfx_demo_dbuf_sva (
  input logic                                   clk,
  input logic                                   reset,
  input logic                                   pixel_valid,
  input logic                                   pixel_ready,
  input gfx_pkg::pixel_t                        pixel,
  input logic                                   hsync,
  input logic                                   vsync,
  input logic                                   active,
  input logic [axi_lite_pkg::axi_addr_bits-1:0] awaddr,
  input logic                                   awvalid,
  input logic                                   awready,
  input logic [axi_lite_pkg::axi_data_bits-1:0] wdata,
  input logic                                   wvalid,
  input logic                                   wready,
  input axi_lite_pkg::axi_resp_t                bresp,
  input logic                                   bvalid,
  input logic                                   bready,
  input logic [axi_lite_pkg::axi_addr_bits-1:0] araddr,
  input logic                                   arvalid,
  input logic                                   arready,
  input axi_lite_pkg::axi_resp_t                rresp,
  input logic                                   rvalid,
  input logic                                   rready,
  input logic                                   swap,
  input logic                                   display_enable,
  input logic                                   frame_start
);
  import axi_lite_pkg::*;

  // output beat frozen while the sink stalls
  pixel_hold: assert property (@(posedge clk) disable iff (reset)
    pixel_valid && !pixel_ready |=> pixel_valid && $stable({pixel, hsync, vsync, active}))
    else $error("pixel beat changed under back-pressure");

  aw_hold: assert property (@(posedge clk) disable iff (reset)
    awvalid && !awready |=> awvalid && $stable(awaddr))
    else $error("awvalid dropped or awaddr moved before awready");

  w_hold: assert property (@(posedge clk) disable iff (reset)
    wvalid && !wready |=> wvalid && $stable(wdata))
    else $error("wvalid dropped or wdata moved before wready");

  ar_hold: assert property (@(posedge clk) disable iff (reset)
    arvalid && !arready |=> arvalid && $stable(araddr))
    else $error("arvalid dropped or araddr moved before arready");

  b_hold: assert property (@(posedge clk) disable iff (reset)
    bvalid && !bready |=> bvalid)
    else $error("bvalid dropped before bready");

  r_hold: assert property (@(posedge clk) disable iff (reset)
    rvalid && !rready |=> rvalid)
    else $error("rvalid dropped before rready");

  // every address in range, so no error response
  b_okay: assert property (@(posedge clk) disable iff (reset)
    bvalid |-> bresp == resp_okay)
    else $error("write response is not okay");

  r_okay: assert property (@(posedge clk) disable iff (reset)
    rvalid |-> rresp == resp_okay)
    else $error("read response is not okay");

  // once the display runs, a swap only lands on a display frame start
  swap_on_start: assert property (@(posedge clk) disable iff (reset)
    swap && display_enable |-> frame_start)
    else $error("swap fired outside a frame start after the first swap");

  swap_pulse: assert property (@(posedge clk) disable iff (reset)
    swap |=> !swap)
    else $error("swap held for more than one cycle");

endmodule

bind gfx_demo_dbuf gfx_demo_dbuf_sva sva_inst (
  .clk           (clk),
  .reset         (reset),
  .pixel_valid   (pixel_valid),
  .pixel_ready   (pixel_ready),
  .pixel         (pixel),
  .hsync         (hsync),
  .vsync         (vsync),
  .active        (active),
  .awaddr        (awaddr),
  .awvalid       (awvalid),
  .awready       (awready),
  .wdata         (wdata),
  .wvalid        (wvalid),
  .wready        (wready),
  .bresp         (bresp),
  .bvalid        (bvalid),
  .bready        (bready),
  .araddr        (araddr),
  .arvalid       (arvalid),
  .arready       (arready),
  .rresp         (rresp),
  .rvalid        (rvalid),
  .rready        (rready),
  .swap          (swap),
  .display_enable(display_enable),
  .frame_start   (frame_start)
);

/* tb/tb_gfx_demo_dbuf.sv */
`timescale 1ns/10ps

module tb_gfx_demo_dbuf;
  import gfx_pkg::*;

  localparam int frames_to_run = 12;
  localparam int reset_cycles = 5;
  localparam int beats_per_frame = h_total * v_total;
  // each beat may take three cycles, doubled for stalls, then a 2x margin
  localparam int cycle_limit = 2 * (frames_to_run * beats_per_frame * 2 * 3 + reset_cycles);

  logic   clk = 1'b0;
  logic   reset;
  logic   pixel_ready = 1'b0;
  logic   pixel_valid;
  pixel_t pixel;
  logic   hsync;
  logic   vsync;
  logic   active;

  integer     seed = 32'hfc1d_e9a3;
  int         cycle_count;
  int         checks = 0;
  int         errors = 0;
  int         frame_err_base = 0;
  int         frames_done = 0;
  int         starts_seen = 0;
  int         beat_count = 0;
  int         mx = 0;
  int         my = 0;
  logic       written_seen = 1'b0;
  frame_num_t exp_num = '0;
  frame_num_t seen_num = '0;

  gfx_demo_dbuf uut (
    .clk        (clk),
    .reset      (reset),
    .pixel_ready(pixel_ready),
    .pixel_valid(pixel_valid),
    .pixel      (pixel),
    .hsync      (hsync),
    .vsync      (vsync),
    .active     (active)
  );

  always #2 clk = ~clk;

  // sink stalls on about one cycle in three
  always @(posedge clk) begin
    #1;
    pixel_ready <= ({$random(seed)} % 3) != 0;
  end

  // active pixel: frame number in red, x in green, y in blue
  function automatic pixel_t pattern_at(frame_num_t n, int px, int py);
    pixel_t p;
    p.red = n;
    p.grn = 4'(px);
    p.blu = 4'(py);
    return p;
  endfunction

  task automatic check_pixel(input pixel_t got, input pixel_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s at (%0d,%0d) got %h expected %h",
               $time, what, mx, my, got, exp);
    end
  endtask

  task automatic check_frame_num(input frame_num_t got, input frame_num_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: frame number got %0d expected %0d", $time, got, exp);
    end
  endtask

  task automatic check_sync(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s at (%0d,%0d) got %b expected %b",
               $time, what, mx, my, got, exp);
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    checks++;
    if (got != exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  // one accepted beat against the raster model
  task automatic take_beat();
    logic exp_active;
    exp_active = (mx < fb_width) && (my < fb_height);
    check_sync(hsync, (mx >= hsync_start) && (mx < hsync_start + hsync_len), "hsync");
    check_sync(vsync, my == vsync_line, "vsync");
    check_sync(active, exp_active, "active");
    if (exp_active) begin
      if (mx == 0 && my == 0) begin
        seen_num = pixel.red;
        check_frame_num(pixel.red, exp_num);
      end
      check_pixel(pixel, pattern_at(exp_num, mx, my), "active pixel");
    end else begin
      check_pixel(pixel, '0, "blank pixel");
    end
    beat_count++;
    if (mx == h_total - 1) begin
      mx = 0;
      my = (my == v_total - 1) ? 0 : my + 1;
    end else begin
      mx++;
    end
  endtask

  // a frame start closes the frame before it
  task automatic close_frame();
    if (starts_seen > 0) begin
      check_count(beat_count, beats_per_frame, "beats in frame");
      if (errors == frame_err_base) begin
        $display("frame %0d: %0d beats, number %0d, ok", frames_done, beat_count, seen_num);
      end else begin
        $display("frame %0d: %0d beats, number %0d, %0d errors",
                 frames_done, beat_count, seen_num, errors - frame_err_base);
      end
      frames_done++;
      exp_num = exp_num + 1'b1;
    end
    starts_seen++;
    beat_count = 0;
    frame_err_base = errors;
  endtask

  // valid and ready are both settled at the falling edge
  always @(negedge clk) begin
    if (!reset) begin
      if (uut.frame_written) begin
        written_seen = 1'b1;
      end
      if (pixel_valid && !written_seen) begin
        errors++;
        $display("error at %0t: pixel beat offered before the first frame was written", $time);
      end
      if (uut.frame_start) begin
        close_frame();
      end
      if (pixel_valid && pixel_ready) begin
        take_beat();
      end
    end
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: not all frames seen");
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #1;
    reset = 1'b0;
    wait (frames_done == frames_to_run);
    $display("frames %0d, checks %0d, errors %0d", frames_done, checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* tb.f */
rtl/gfx_pkg.sv
rtl/axi_lite_pkg.sv
rtl/gfx_test_pattern.sv
rtl/fb_writer.sv
rtl/dbuf_controller.sv
rtl/fb_pixel_stream.sv
rtl/gfx_demo_dbuf.sv
tb/gfx_demo_dbuf_sva.sv
tb/tb_gfx_demo_dbuf.sv

/* run.sh */
#!/usr/bin/env bash
# build the testbench with Verilator, run it and search the log for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f tb.f --top-module tb_gfx_demo_dbuf -o tb_sim \
  && ./obj_dir/tb_sim 2>&1 | tee sim.log \
  || { echo "build or simulation error"; exit 1; }

grep -q "ALL CHECKS PASSED" sim.log \
  && { echo "result: pass"; exit 0; } \
  || { echo "result: fail"; exit 1; }
